// ==== hw/rob_pkg.sv ====
// Shared types and default sizes for the reorder buffer; import into any ROB block
`default_nettype none

package rob_pkg;

  // ========================================
  // Widths
  // ========================================
  localparam int PC_W    = 32;  // Program counter
  localparam int ECODE_W = 6;   // Exception cause

  // Default sizing, overridden from rob_top only
  localparam int DEF_ROB_DEPTH    = 16;  // Must stay a power of two
  localparam int DEF_DECODE_WIDTH = 2;   // Allocations per cycle
  localparam int DEF_COMMIT_WIDTH = 2;   // Completion ports
  localparam int DEF_RETIRE_WIDTH = 4;   // Max retirements per cycle

  // ========================================
  // Entry contents
  // ========================================
  // Operation class, only what retirement ordering cares about
  typedef enum logic [1:0] {
    OP_ALU    = 2'd0,
    OP_BRANCH = 2'd1,  // One per retire group
    OP_LOAD   = 2'd2,
    OP_STORE  = 2'd3   // One per retire group
  } rob_op_e;

  // One buffer slot, 43 bits
  typedef struct packed {
    logic [PC_W-1:0]    pc;
    rob_op_e            op;
    logic               complete;   // Set by a commit port
    logic               exception;  // Closes the retire group
    logic               redirect;   // Closes the retire group too
    logic [ECODE_W-1:0] ecode;      // Valid with exception
  } rob_entry_t;

  // ========================================
  // Config register map
  // ========================================
  typedef enum logic [1:0] {
    CFG_RETIRE_LIMIT = 2'd0,  // RW, 3 bits
    CFG_STAT_RETIRED = 2'd1,  // RO, wrapping count
    CFG_STAT_EXC     = 2'd2   // RO, wrapping count
  } rob_cfg_addr_e;

endpackage

`default_nettype wire

// ==== hw/rob_alloc_if.sv ====
// Allocation handshake between dispatch and the ROB entry store; one group per accepting edge
`timescale 1ns/100ps
`default_nettype none

interface rob_alloc_if #(
  parameter int DECODE_WIDTH = rob_pkg::DEF_DECODE_WIDTH,
  parameter int ROB_DEPTH    = rob_pkg::DEF_ROB_DEPTH
);
  import rob_pkg::*;

  localparam int IDX_W = $clog2(ROB_DEPTH);

  logic [DECODE_WIDTH-1:0]            valid;    // Prefix mask from slot 0 up
  logic [DECODE_WIDTH-1:0][PC_W-1:0]  pc;
  rob_op_e [DECODE_WIDTH-1:0]         op;
  logic                               ready;    // Room for a full group
  logic [DECODE_WIDTH-1:0][IDX_W-1:0] rob_idx;  // Tail + slot, shown before the edge

  // Dispatch side
  modport source (output valid, pc, op, input ready, rob_idx);

  // Buffer side
  modport store (input valid, pc, op, output ready, rob_idx);

endinterface

`default_nettype wire

// ==== hw/rob_cmt_if.sv ====
// Completion ports from execution units into the ROB entry store; valid only, always accepted
`timescale 1ns/100ps
`default_nettype none

interface rob_cmt_if #(
  parameter int COMMIT_WIDTH = rob_pkg::DEF_COMMIT_WIDTH,
  parameter int ROB_DEPTH    = rob_pkg::DEF_ROB_DEPTH
);
  import rob_pkg::*;

  localparam int IDX_W = $clog2(ROB_DEPTH);

  logic [COMMIT_WIDTH-1:0]              valid;
  logic [COMMIT_WIDTH-1:0][IDX_W-1:0]   rob_idx;    // Must point at a live entry
  logic [COMMIT_WIDTH-1:0]              exception;
  logic [COMMIT_WIDTH-1:0]              redirect;
  logic [COMMIT_WIDTH-1:0][ECODE_W-1:0] ecode;

  modport unit  (output valid, rob_idx, exception, redirect, ecode);
  modport store (input  valid, rob_idx, exception, redirect, ecode);

endinterface

`default_nettype wire

// ==== hw/rob_entry_store.sv ====
// ROB entry array with head/tail pointers; allocates at tail, marks completions, frees at head
`timescale 1ns/100ps
`default_nettype none

module rob_entry_store #(
  parameter int ROB_DEPTH    = rob_pkg::DEF_ROB_DEPTH,
  parameter int DECODE_WIDTH = rob_pkg::DEF_DECODE_WIDTH,
  parameter int COMMIT_WIDTH = rob_pkg::DEF_COMMIT_WIDTH,
  parameter int RETIRE_WIDTH = rob_pkg::DEF_RETIRE_WIDTH
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   flush,
  rob_alloc_if.store                             alloc,
  rob_cmt_if.store                               cmt,
  output rob_pkg::rob_entry_t [RETIRE_WIDTH-1:0] head_entries,
  output logic [RETIRE_WIDTH-1:0]                head_live,
  input  logic [$clog2(RETIRE_WIDTH+1)-1:0]      retire_cnt
);
  import rob_pkg::*;

  localparam int IDX_W  = $clog2(ROB_DEPTH);
  localparam int PTR_W  = IDX_W + 1;              // Extra wrap bit for full/empty
  localparam int ACNT_W = $clog2(DECODE_WIDTH + 1);

  // ========================================
  // State and decode
  // ========================================
  rob_entry_t entries_q [ROB_DEPTH];  // Payload only, liveness comes from pointers
  logic [PTR_W-1:0] head_ptr;         // Oldest entry
  logic [PTR_W-1:0] tail_ptr;         // Next free slot

  logic [IDX_W-1:0]              head_idx;
  logic [IDX_W-1:0]              tail_idx;
  logic [PTR_W-1:0]              used;         // Live entry count, 0..ROB_DEPTH
  logic [ACNT_W-1:0]             alloc_cnt;    // Size of the offered group
  logic                          alloc_fire;
  rob_entry_t [DECODE_WIDTH-1:0] alloc_entry;  // Fresh entries, not yet complete

  assign head_idx = head_ptr[IDX_W-1:0];
  assign tail_idx = tail_ptr[IDX_W-1:0];
  assign used     = tail_ptr - head_ptr;  // Wrap bit keeps full distinct from empty

  // ========================================
  // Allocation
  // ========================================
  // All-or-nothing, so only a full group's worth of room counts
  assign alloc.ready = (PTR_W'(ROB_DEPTH) - used) >= PTR_W'(DECODE_WIDTH);
  assign alloc_fire  = (|alloc.valid) && alloc.ready && !flush;

  always_comb begin
    alloc_cnt = '0;
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      alloc.rob_idx[i] = tail_idx + IDX_W'(i);  // Wraps with the array
      if (alloc.valid[i]) begin
        alloc_cnt = alloc_cnt + 1'b1;
      end
      alloc_entry[i] = '{
        pc:        alloc.pc[i],
        op:        alloc.op[i],
        complete:  1'b0,
        exception: 1'b0,
        redirect:  1'b0,
        ecode:     '0
      };
    end
  end

  // Payload array, allocation fills slots at tail and completions mark status
  always_ff @(posedge clk) begin
    if (!flush) begin
      if (alloc_fire) begin
        for (int i = 0; i < DECODE_WIDTH; i++) begin
          if (alloc.valid[i]) begin
            entries_q[alloc.rob_idx[i]] <= alloc_entry[i];
          end
        end
      end
      // Completions land on live entries only, never on this edge's new slots
      for (int j = 0; j < COMMIT_WIDTH; j++) begin
        if (cmt.valid[j]) begin
          entries_q[cmt.rob_idx[j]].complete  <= 1'b1;
          entries_q[cmt.rob_idx[j]].exception <= cmt.exception[j];
          entries_q[cmt.rob_idx[j]].redirect  <= cmt.redirect[j];
          entries_q[cmt.rob_idx[j]].ecode     <= cmt.ecode[j];
        end
      end
    end
  end

  // ========================================
  // Pointers
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_ptr <= '0;
      tail_ptr <= '0;
    end else if (flush) begin
      // Empty and restart at index 0
      head_ptr <= '0;
      tail_ptr <= '0;
    end else begin
      head_ptr <= head_ptr + PTR_W'(retire_cnt);  // Selector never exceeds live count
      if (alloc_fire) begin
        tail_ptr <= tail_ptr + PTR_W'(alloc_cnt);
      end
    end
  end

  // Head window for the selector
  always_comb begin
    for (int i = 0; i < RETIRE_WIDTH; i++) begin
      head_entries[i] = entries_q[head_idx + IDX_W'(i)];
      head_live[i]    = !flush && (used > PTR_W'(i));  // Nothing retires in a flush cycle
    end
  end

endmodule

`default_nettype wire

// ==== hw/rob_retire_select.sv ====
// Picks this cycle's in-order retire group from the ROB head window; purely combinational
`timescale 1ns/100ps
`default_nettype none

module rob_retire_select #(
  parameter int RETIRE_WIDTH = rob_pkg::DEF_RETIRE_WIDTH
) (
  input  rob_pkg::rob_entry_t [RETIRE_WIDTH-1:0] head_entries,
  input  logic [RETIRE_WIDTH-1:0]                head_live,
  input  logic [$clog2(RETIRE_WIDTH+1)-1:0]      retire_limit,
  output logic [RETIRE_WIDTH-1:0]                retire_mask,
  output logic [$clog2(RETIRE_WIDTH+1)-1:0]      retire_cnt,
  output logic [$clog2(RETIRE_WIDTH+1)-1:0]      exc_retired
);
  import rob_pkg::*;

  localparam int CNT_W = $clog2(RETIRE_WIDTH + 1);

  // ========================================
  // Per-slot classification
  // ========================================
  logic [RETIRE_WIDTH-1:0] slot_done;  // Live and complete
  logic [RETIRE_WIDTH-1:0] slot_br;
  logic [RETIRE_WIDTH-1:0] slot_st;
  logic [RETIRE_WIDTH-1:0] slot_last;  // Exception or redirect ends the group

  always_comb begin
    for (int i = 0; i < RETIRE_WIDTH; i++) begin
      slot_done[i] = head_live[i] && head_entries[i].complete;
      slot_br[i]   = head_entries[i].op == OP_BRANCH;
      slot_st[i]   = head_entries[i].op == OP_STORE;
      slot_last[i] = head_entries[i].exception || head_entries[i].redirect;
    end
  end

  // ========================================
  // Group walk
  // ========================================
  // Walk from the head, stop at the first slot that breaks a rule
  logic             grp_open;  // Still taking slots
  logic             br_seen;   // A branch is already in the group
  logic             st_seen;   // A store is already in the group
  logic [CNT_W-1:0] sel_cnt;
  logic [CNT_W-1:0] exc_cnt;

  always_comb begin
    grp_open = 1'b1;
    br_seen  = 1'b0;
    st_seen  = 1'b0;
    sel_cnt  = '0;
    exc_cnt  = '0;
    for (int i = 0; i < RETIRE_WIDTH; i++) begin
      if (!slot_done[i]) begin
        grp_open = 1'b0;  // In-order, a hole blocks younger slots
      end
      if (sel_cnt >= retire_limit) begin
        grp_open = 1'b0;  // Programmed width reached
      end
      if (slot_br[i] && br_seen) begin
        grp_open = 1'b0;
      end
      if (slot_st[i] && st_seen) begin
        grp_open = 1'b0;
      end

      retire_mask[i] = grp_open;

      if (grp_open) begin
        sel_cnt = sel_cnt + 1'b1;
        br_seen = br_seen | slot_br[i];
        st_seen = st_seen | slot_st[i];
        if (head_entries[i].exception) begin
          exc_cnt = exc_cnt + 1'b1;
        end
        if (slot_last[i]) begin
          grp_open = 1'b0;  // Younger slots wait for the next cycle
        end
      end
    end
  end

  assign retire_cnt  = sel_cnt;
  assign exc_retired = exc_cnt;  // At most one, kept wide for the stats adder

endmodule

`default_nettype wire

// ==== hw/rob_cfg_regs.sv ====
// ROB config and statistics registers behind a simple read/write port
`timescale 1ns/100ps
`default_nettype none

module rob_cfg_regs #(
  parameter int RETIRE_WIDTH = rob_pkg::DEF_RETIRE_WIDTH
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              cfg_wr,
  input  rob_pkg::rob_cfg_addr_e            cfg_addr,
  input  logic [31:0]                       cfg_wdata,
  output logic [31:0]                       cfg_rdata,
  output logic [$clog2(RETIRE_WIDTH+1)-1:0] retire_limit,
  input  logic [$clog2(RETIRE_WIDTH+1)-1:0] retire_cnt,
  input  logic [$clog2(RETIRE_WIDTH+1)-1:0] exc_retired
);
  import rob_pkg::*;

  localparam int CNT_W = $clog2(RETIRE_WIDTH + 1);

  logic [CNT_W-1:0] limit_q;         // Max entries per retire group
  logic [CNT_W-1:0] limit_wr_val;    // Clamped write data
  logic [31:0]      stat_retired_q;  // Wraps
  logic [31:0]      stat_exc_q;      // Wraps

  // ========================================
  // Limit write path
  // ========================================
  always_comb begin
    if (cfg_wdata == 32'd0) begin
      limit_wr_val = CNT_W'(1);  // Zero would stall retirement forever
    end else if (cfg_wdata > 32'(RETIRE_WIDTH)) begin
      limit_wr_val = CNT_W'(RETIRE_WIDTH);
    end else begin
      limit_wr_val = cfg_wdata[CNT_W-1:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      limit_q        <= CNT_W'(RETIRE_WIDTH);  // Full width out of reset
      stat_retired_q <= '0;
      stat_exc_q     <= '0;
    end else begin
      if (cfg_wr && cfg_addr == CFG_RETIRE_LIMIT) begin
        limit_q <= limit_wr_val;
      end
      stat_retired_q <= stat_retired_q + 32'(retire_cnt);
      stat_exc_q     <= stat_exc_q + 32'(exc_retired);
    end
  end

  assign retire_limit = limit_q;

  // Read mux, writes to the counters fall through
  always_comb begin
    case (cfg_addr)
      CFG_RETIRE_LIMIT: cfg_rdata = 32'(limit_q);
      CFG_STAT_RETIRED: cfg_rdata = stat_retired_q;
      CFG_STAT_EXC:     cfg_rdata = stat_exc_q;
      default:          cfg_rdata = '0;  // Unmapped address
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/rob_top.sv ====
// Reorder buffer top level; plain ports for dispatch, completion, retire broadcast and config
`timescale 1ns/100ps
`default_nettype none

module rob_top #(
  parameter int ROB_DEPTH    = rob_pkg::DEF_ROB_DEPTH,
  parameter int DECODE_WIDTH = rob_pkg::DEF_DECODE_WIDTH,
  parameter int COMMIT_WIDTH = rob_pkg::DEF_COMMIT_WIDTH,
  parameter int RETIRE_WIDTH = rob_pkg::DEF_RETIRE_WIDTH
) (
  input  logic                                                 clk,
  input  logic                                                 rst_n,
  input  logic                                                 flush,
  // Dispatch
  input  logic [DECODE_WIDTH-1:0]                              alloc_valid,
  input  logic [DECODE_WIDTH-1:0][rob_pkg::PC_W-1:0]           alloc_pc,
  input  rob_pkg::rob_op_e [DECODE_WIDTH-1:0]                  alloc_op,
  output logic                                                 alloc_ready,
  output logic [DECODE_WIDTH-1:0][$clog2(ROB_DEPTH)-1:0]       alloc_rob_idx,
  // Completion
  input  logic [COMMIT_WIDTH-1:0]                              cmt_valid,
  input  logic [COMMIT_WIDTH-1:0][$clog2(ROB_DEPTH)-1:0]       cmt_rob_idx,
  input  logic [COMMIT_WIDTH-1:0]                              cmt_exception,
  input  logic [COMMIT_WIDTH-1:0]                              cmt_redirect,
  input  logic [COMMIT_WIDTH-1:0][rob_pkg::ECODE_W-1:0]        cmt_ecode,
  // Retire broadcast
  output logic [RETIRE_WIDTH-1:0]                              retire_valid,
  output logic [RETIRE_WIDTH-1:0][rob_pkg::PC_W-1:0]           retire_pc,
  output rob_pkg::rob_op_e [RETIRE_WIDTH-1:0]                  retire_op,
  output logic [RETIRE_WIDTH-1:0]                              retire_exception,
  output logic [RETIRE_WIDTH-1:0][rob_pkg::ECODE_W-1:0]        retire_ecode,
  // Config port
  input  logic                                                 cfg_wr,
  input  rob_pkg::rob_cfg_addr_e                               cfg_addr,
  input  logic [31:0]                                          cfg_wdata,
  output logic [31:0]                                          cfg_rdata
);
  import rob_pkg::*;

  localparam int CNT_W = $clog2(RETIRE_WIDTH + 1);

  rob_entry_t [RETIRE_WIDTH-1:0] head_entries;
  logic [RETIRE_WIDTH-1:0]       head_live;
  logic [RETIRE_WIDTH-1:0]       retire_mask;
  logic [CNT_W-1:0]              retire_cnt;
  logic [CNT_W-1:0]              exc_retired;
  logic [CNT_W-1:0]              retire_limit;

  // ========================================
  // Port to interface mapping
  // ========================================
  rob_alloc_if #(.DECODE_WIDTH(DECODE_WIDTH), .ROB_DEPTH(ROB_DEPTH)) alloc_bus ();
  rob_cmt_if   #(.COMMIT_WIDTH(COMMIT_WIDTH), .ROB_DEPTH(ROB_DEPTH)) cmt_bus ();

  assign alloc_bus.valid = alloc_valid;
  assign alloc_bus.pc    = alloc_pc;
  assign alloc_bus.op    = alloc_op;
  assign alloc_ready     = alloc_bus.ready;
  assign alloc_rob_idx   = alloc_bus.rob_idx;  // Combinational, tag before the edge

  assign cmt_bus.valid     = cmt_valid;
  assign cmt_bus.rob_idx   = cmt_rob_idx;
  assign cmt_bus.exception = cmt_exception;
  assign cmt_bus.redirect  = cmt_redirect;
  assign cmt_bus.ecode     = cmt_ecode;

  // ========================================
  // Blocks
  // ========================================
  rob_entry_store #(
    .ROB_DEPTH   (ROB_DEPTH),
    .DECODE_WIDTH(DECODE_WIDTH),
    .COMMIT_WIDTH(COMMIT_WIDTH),
    .RETIRE_WIDTH(RETIRE_WIDTH)
  ) store_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush       (flush),
    .alloc       (alloc_bus),
    .cmt         (cmt_bus),
    .head_entries(head_entries),
    .head_live   (head_live),
    .retire_cnt  (retire_cnt)
  );

  rob_retire_select #(.RETIRE_WIDTH(RETIRE_WIDTH)) select_i (
    .head_entries(head_entries),
    .head_live   (head_live),
    .retire_limit(retire_limit),
    .retire_mask (retire_mask),
    .retire_cnt  (retire_cnt),
    .exc_retired (exc_retired)
  );

  rob_cfg_regs #(.RETIRE_WIDTH(RETIRE_WIDTH)) cfg_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg_wr      (cfg_wr),
    .cfg_addr    (cfg_addr),
    .cfg_wdata   (cfg_wdata),
    .cfg_rdata   (cfg_rdata),
    .retire_limit(retire_limit),
    .retire_cnt  (retire_cnt),
    .exc_retired (exc_retired)
  );

  // Broadcast, payload zeroed outside the group
  always_comb begin
    for (int i = 0; i < RETIRE_WIDTH; i++) begin
      retire_valid[i]     = retire_mask[i];
      retire_pc[i]        = retire_mask[i] ? head_entries[i].pc : '0;
      retire_op[i]        = retire_mask[i] ? head_entries[i].op : OP_ALU;
      retire_exception[i] = retire_mask[i] && head_entries[i].exception;
      retire_ecode[i]     = retire_mask[i] ? head_entries[i].ecode : '0;
    end
  end

endmodule

`default_nettype wire

// ==== tb/rob_checker.sv ====
// Concurrent assertions on the ROB retire broadcast and allocation port; bound into rob_top
`timescale 1ns/100ps
`default_nettype none

module rob_checker #(
  parameter int ROB_DEPTH    = rob_pkg::DEF_ROB_DEPTH,
  parameter int DECODE_WIDTH = rob_pkg::DEF_DECODE_WIDTH,
  parameter int RETIRE_WIDTH = rob_pkg::DEF_RETIRE_WIDTH
) (
  input logic                                           clk,
  input logic                                           rst_n,
  input logic                                           flush,
  input logic                                           alloc_ready,
  input logic [DECODE_WIDTH-1:0][$clog2(ROB_DEPTH)-1:0] alloc_rob_idx,
  input logic [RETIRE_WIDTH-1:0]                        retire_valid,
  input rob_pkg::rob_op_e [RETIRE_WIDTH-1:0]            retire_op
);
  import rob_pkg::*;

  int st_cnt;  // Stores in this cycle's group
  int br_cnt;  // Branches in this cycle's group

  always_comb begin
    st_cnt = 0;
    br_cnt = 0;
    for (int i = 0; i < RETIRE_WIDTH; i++) begin
      if (retire_valid[i] && retire_op[i] == OP_STORE) st_cnt++;
      if (retire_valid[i] && retire_op[i] == OP_BRANCH) br_cnt++;
    end
  end

  // ========================================
  // Properties
  // ========================================
  // Prefix mask means v plus one is a power of two
  a_prefix: assert property (@(posedge clk) disable iff (!rst_n)
    (retire_valid & (retire_valid + 1'b1)) == '0)
    else $error("retire_valid is not a prefix mask");

  a_reset_quiet: assert property (@(posedge clk) !rst_n |-> retire_valid == '0)
    else $error("retire_valid set during reset");

  a_one_store_branch: assert property (@(posedge clk) disable iff (!rst_n)
    st_cnt <= 1 && br_cnt <= 1)
    else $error("retire group holds two stores or two branches");

  // Tail moves only on acceptance, and rob_idx follows the tail
  a_no_alloc_stalled: assert property (@(posedge clk) disable iff (!rst_n)
    (!alloc_ready && !flush) |=> alloc_rob_idx == $past(alloc_rob_idx))
    else $error("allocation accepted while alloc_ready was low");

endmodule

bind rob_top rob_checker #(
  .ROB_DEPTH   (ROB_DEPTH),
  .DECODE_WIDTH(DECODE_WIDTH),
  .RETIRE_WIDTH(RETIRE_WIDTH)
) checker_i (
  .clk          (clk),
  .rst_n        (rst_n),
  .flush        (flush),
  .alloc_ready  (alloc_ready),
  .alloc_rob_idx(alloc_rob_idx),
  .retire_valid (retire_valid),
  .retire_op    (retire_op)
);

`default_nettype wire

// ==== tb/rob_tb.sv ====
// Directed testbench for the reorder buffer; top module rob_tb, compiled with project.f
`timescale 1ns/100ps
`default_nettype none

module rob_tb;
  import rob_pkg::*;

  localparam int ROB_DEPTH    = DEF_ROB_DEPTH;
  localparam int DECODE_WIDTH = DEF_DECODE_WIDTH;
  localparam int COMMIT_WIDTH = DEF_COMMIT_WIDTH;
  localparam int RETIRE_WIDTH = DEF_RETIRE_WIDTH;
  localparam int IDX_W        = $clog2(ROB_DEPTH);
  localparam int CLK_PERIOD   = 20;
  localparam int SEED         = 28;
  // Reset, then per test: state, order, capacity, groups, registers, flush
  localparam int TEST_CYCLES  = 10 + 5 + 30 + 60 + 40 + 60 + 30;
  localparam int WATCHDOG_NS  = TEST_CYCLES * 4 * CLK_PERIOD;

  logic                                 clk = 1'b0;
  logic                                 rst_n;
  logic                                 flush;
  logic [DECODE_WIDTH-1:0]              alloc_valid;
  logic [DECODE_WIDTH-1:0][PC_W-1:0]    alloc_pc;
  rob_op_e [DECODE_WIDTH-1:0]           alloc_op;
  logic                                 alloc_ready;
  logic [DECODE_WIDTH-1:0][IDX_W-1:0]   alloc_rob_idx;
  logic [COMMIT_WIDTH-1:0]              cmt_valid;
  logic [COMMIT_WIDTH-1:0][IDX_W-1:0]   cmt_rob_idx;
  logic [COMMIT_WIDTH-1:0]              cmt_exception;
  logic [COMMIT_WIDTH-1:0]              cmt_redirect;
  logic [COMMIT_WIDTH-1:0][ECODE_W-1:0] cmt_ecode;
  logic [RETIRE_WIDTH-1:0]              retire_valid;
  logic [RETIRE_WIDTH-1:0][PC_W-1:0]    retire_pc;
  rob_op_e [RETIRE_WIDTH-1:0]           retire_op;
  logic [RETIRE_WIDTH-1:0]              retire_exception;
  logic [RETIRE_WIDTH-1:0][ECODE_W-1:0] retire_ecode;
  logic                                 cfg_wr;
  rob_cfg_addr_e                        cfg_addr;
  logic [31:0]                          cfg_wdata;
  logic [31:0]                          cfg_rdata;

  // Program-order model, one element per live entry
  typedef struct packed {
    logic [PC_W-1:0]    pc;
    rob_op_e            op;
    logic [IDX_W-1:0]   idx;
    logic               done;
    logic               exc;
    logic               red;
    logic [ECODE_W-1:0] ecode;
  } mdl_entry_t;

  mdl_entry_t       mdl[$];
  logic [IDX_W-1:0] tail_mdl;       // Next index the buffer hands out
  int               limit_mdl;
  int               grp_n = 0;      // Group size seen before the coming edge
  int               retired_total;
  int               exc_total;
  int               err_cnt = 0;
  int               chk_cnt = 0;
  logic [PC_W-1:0]  next_pc;

  rob_top #(
    .ROB_DEPTH   (ROB_DEPTH),
    .DECODE_WIDTH(DECODE_WIDTH),
    .COMMIT_WIDTH(COMMIT_WIDTH),
    .RETIRE_WIDTH(RETIRE_WIDTH)
  ) rob_top_i (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ========================================
  // Reference model
  // ========================================
  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Fail at time %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  function automatic int clamp_limit(input logic [31:0] v);
    if (v == 0) return 1;
    if (v > RETIRE_WIDTH) return RETIRE_WIDTH;
    return int'(v);
  endfunction

  // Group from the head: in order, limit, one branch, one store, exc/redirect closes it
  function automatic int predict_group();
    int n = 0;
    bit br = 1'b0;
    bit st = 1'b0;
    if (flush) return 0;
    for (int k = 0; k < RETIRE_WIDTH && k < mdl.size(); k++) begin
      if (!mdl[k].done || n >= limit_mdl) break;
      if ((mdl[k].op == OP_BRANCH && br) || (mdl[k].op == OP_STORE && st)) break;
      n++;
      br |= mdl[k].op == OP_BRANCH;
      st |= mdl[k].op == OP_STORE;
      if (mdl[k].exc || mdl[k].red) break;
    end
    return n;
  endfunction

  // Outputs are settled mid-cycle
  always @(negedge clk) begin : retire_monitor
    int n;
    if (!rst_n) begin
      grp_n = 0;
    end else begin
      n = predict_group();
      for (int i = 0; i < RETIRE_WIDTH; i++) begin
        check_eq($sformatf("retire_valid[%0d]", i), retire_valid[i], i < n);
        if (i < n) begin
          check_eq($sformatf("retire_pc[%0d]", i), retire_pc[i], mdl[i].pc);
          check_eq($sformatf("retire_op[%0d]", i), retire_op[i], mdl[i].op);
          check_eq($sformatf("retire_exception[%0d]", i), retire_exception[i], mdl[i].exc);
          check_eq($sformatf("retire_ecode[%0d]", i), retire_ecode[i], mdl[i].ecode);
        end
      end
      check_eq("alloc_ready", alloc_ready, (ROB_DEPTH - mdl.size()) >= DECODE_WIDTH);
      for (int i = 0; i < DECODE_WIDTH; i++) begin
        if (alloc_valid[i]) begin
          check_eq($sformatf("alloc_rob_idx[%0d]", i), alloc_rob_idx[i],
                   (int'(tail_mdl) + i) % ROB_DEPTH);
        end
      end
      grp_n = n;
    end
  end

  always @(posedge clk) begin : model_update
    mdl_entry_t e;
    bit can_alloc;
    if (!rst_n) begin
      mdl.delete();
      tail_mdl      = '0;
      limit_mdl     = RETIRE_WIDTH;
      retired_total = 0;
      exc_total     = 0;
    end else begin
      can_alloc = (ROB_DEPTH - mdl.size()) >= DECODE_WIDTH;  // Room before this edge
      if (cfg_wr && cfg_addr == CFG_RETIRE_LIMIT) limit_mdl = clamp_limit(cfg_wdata);
      if (flush) begin
        mdl.delete();
        tail_mdl = '0;
      end else begin
        repeat (grp_n) begin
          retired_total++;
          if (mdl[0].exc) exc_total++;
          void'(mdl.pop_front());
        end
        for (int p = 0; p < COMMIT_WIDTH; p++) begin
          for (int q = 0; q < mdl.size(); q++) begin
            if (cmt_valid[p] && mdl[q].idx == cmt_rob_idx[p]) begin
              mdl[q].done  = 1'b1;
              mdl[q].exc   = cmt_exception[p];
              mdl[q].red   = cmt_redirect[p];
              mdl[q].ecode = cmt_ecode[p];
            end
          end
        end
        for (int i = 0; i < DECODE_WIDTH; i++) begin
          if (can_alloc && alloc_valid[i]) begin
            e = '{pc: alloc_pc[i], op: alloc_op[i], idx: tail_mdl, default: '0};
            mdl.push_back(e);
            tail_mdl++;  // Wraps with the array
          end
        end
      end
    end
  end

  // ========================================
  // Drive tasks, entered and left 2 ns after an edge
  // ========================================
  task automatic drive_alloc(input int n, input rob_op_e op0, input rob_op_e op1);
    alloc_valid = (n >= 2) ? 2'b11 : 2'b01;
    alloc_pc[0] = next_pc;
    alloc_pc[1] = next_pc + 4;
    alloc_op[0] = op0;
    alloc_op[1] = op1;
    next_pc     = next_pc + 8;
  endtask

  // Group stays up until the handshake edge
  task automatic wait_accept();
    int guard = 0;
    while (!alloc_ready && guard < 50) begin
      @(posedge clk);
      #2;
      guard++;
    end
    if (!alloc_ready) begin
      err_cnt++;
      $display("Allocation never accepted, alloc_ready stayed low");
    end
    @(posedge clk);
    #2;
    alloc_valid = '0;
  endtask

  task automatic alloc_group(input int n, input rob_op_e op0, input rob_op_e op1);
    drive_alloc(n, op0, op1);
    wait_accept();
  endtask

  // Port 0 carries the status flags, port 1 completes cleanly
  task automatic commit(input int n, input logic [IDX_W-1:0] i0, input logic [IDX_W-1:0] i1,
                        input logic exc0, input logic red0, input logic [ECODE_W-1:0] ec0);
    cmt_valid      = (n >= 2) ? 2'b11 : 2'b01;
    cmt_rob_idx[0] = i0;
    cmt_rob_idx[1] = i1;
    cmt_exception  = {1'b0, exc0};
    cmt_redirect   = {1'b0, red0};
    cmt_ecode[0]   = ec0;
    cmt_ecode[1]   = '0;
    @(posedge clk);
    #2;
    cmt_valid = '0;
  endtask

  task automatic complete_all();
    logic [IDX_W-1:0] ids[$];
    foreach (mdl[k]) ids.push_back(mdl[k].idx);
    for (int k = 0; k < ids.size(); k += 2) begin
      if (k + 1 < ids.size()) commit(2, ids[k], ids[k+1], 1'b0, 1'b0, '0);
      else commit(1, ids[k], '0, 1'b0, 1'b0, '0);
    end
  endtask

  task automatic drain();
    int guard = 0;
    while ((mdl.size() != 0 || retire_valid != '0) && guard < 40) begin
      @(posedge clk);
      #2;
      guard++;
    end
    if (mdl.size() != 0) begin
      err_cnt++;
      $display("Retirement stalled with %0d entries left in the buffer", mdl.size());
    end
  endtask

  task automatic write_reg(input rob_cfg_addr_e a, input logic [31:0] d);
    cfg_wr    = 1'b1;
    cfg_addr  = a;
    cfg_wdata = d;
    @(posedge clk);
    #2;
    cfg_wr = 1'b0;
  endtask

  task automatic read_check(input rob_cfg_addr_e a, input logic [31:0] exp, input string name);
    cfg_addr = a;
    #1;
    check_eq(name, cfg_rdata, exp);
    @(posedge clk);
    #2;
  endtask

  // ========================================
  // Tests
  // ========================================
  task automatic test_reset_state();
    check_eq("alloc_ready", alloc_ready, 1'b1);
    check_eq("retire_valid", retire_valid, '0);
    read_check(CFG_RETIRE_LIMIT, RETIRE_WIDTH, "cfg_rdata retire limit");
    read_check(CFG_STAT_RETIRED, 0, "cfg_rdata retired count");
    read_check(CFG_STAT_EXC, 0, "cfg_rdata exception count");
  endtask

  task automatic test_program_order();
    logic [IDX_W-1:0] ids[8];
    logic [IDX_W-1:0] tmp;
    int j;
    for (int k = 0; k < 4; k++) alloc_group(2, OP_ALU, OP_ALU);
    foreach (ids[k]) ids[k] = mdl[k].idx;
    for (int k = 7; k > 0; k--) begin  // Shuffle completion order
      j      = int'($urandom % (k + 1));
      tmp    = ids[k];
      ids[k] = ids[j];
      ids[j] = tmp;
    end
    for (int k = 0; k < 8; k += 2) commit(2, ids[k], ids[k+1], 1'b0, 1'b0, '0);
    drain();
  endtask

  task automatic test_capacity();
    for (int k = 0; k < 8; k++) alloc_group(2, OP_LOAD, OP_ALU);  // Fills all 16
    drive_alloc(2, OP_ALU, OP_ALU);  // Held against back-pressure
    repeat (3) begin
      check_eq("alloc_ready", alloc_ready, 1'b0);
      @(posedge clk);
      #2;
    end
    commit(2, mdl[0].idx, mdl[1].idx, 1'b0, 1'b0, '0);
    wait_accept();
    complete_all();
    drain();
  endtask

  task automatic test_group_rules();
    logic [IDX_W-1:0] ids[10];
    alloc_group(2, OP_STORE, OP_STORE);
    alloc_group(2, OP_BRANCH, OP_BRANCH);
    alloc_group(2, OP_ALU, OP_ALU);
    alloc_group(2, OP_ALU, OP_LOAD);
    alloc_group(2, OP_ALU, OP_ALU);
    foreach (ids[k]) ids[k] = mdl[k].idx;
    // Youngest first, so the head completes last and nothing retires early
    for (int k = 9; k > 0; k -= 2) begin
      commit(2, ids[k], ids[k-1], k == 5, k == 7, (k == 5) ? 6'h2a : 6'h00);
    end
    drain();
  endtask

  task automatic test_registers();
    write_reg(CFG_RETIRE_LIMIT, 32'd1);
    read_check(CFG_RETIRE_LIMIT, 1, "cfg_rdata retire limit");
    alloc_group(2, OP_ALU, OP_LOAD);
    alloc_group(2, OP_STORE, OP_ALU);
    alloc_group(2, OP_BRANCH, OP_ALU);
    complete_all();
    drain();
    read_check(CFG_STAT_RETIRED, retired_total, "cfg_rdata retired count");
    read_check(CFG_STAT_EXC, exc_total, "cfg_rdata exception count");
    write_reg(CFG_RETIRE_LIMIT, 32'd9);
    read_check(CFG_RETIRE_LIMIT, RETIRE_WIDTH, "cfg_rdata clamped limit");
  endtask

  task automatic test_flush();
    for (int k = 0; k < 7; k++) alloc_group(2, OP_ALU, OP_STORE);
    alloc_group(1, OP_LOAD, OP_ALU);  // 15 live, too little room for a group
    commit(1, mdl[2].idx, '0, 1'b0, 1'b0, '0);  // Not the head, so nothing retires
    check_eq("alloc_ready", alloc_ready, 1'b0);
    flush = 1'b1;
    @(posedge clk);
    #2;
    flush = 1'b0;
    check_eq("alloc_ready", alloc_ready, 1'b1);
    check_eq("alloc_rob_idx[0]", alloc_rob_idx[0], '0);
    alloc_group(2, OP_BRANCH, OP_ALU);
    repeat (4) begin
      check_eq("retire_valid", retire_valid, '0);
      @(posedge clk);
      #2;
    end
    complete_all();
    drain();
  endtask

  // ========================================
  // Sequence and watchdog
  // ========================================
  initial begin
    void'($urandom(SEED));
    rst_n         = 1'b0;
    flush         = 1'b0;
    alloc_valid   = '0;
    alloc_pc      = '0;
    foreach (alloc_op[i]) alloc_op[i] = OP_ALU;
    cmt_valid     = '0;
    cmt_rob_idx   = '0;
    cmt_exception = '0;
    cmt_redirect  = '0;
    cmt_ecode     = '0;
    cfg_wr        = 1'b0;
    cfg_addr      = CFG_RETIRE_LIMIT;
    cfg_wdata     = '0;
    next_pc       = 32'h0000_1000;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    test_reset_state();
    test_program_order();
    test_capacity();
    test_group_rules();
    test_registers();
    test_flush();
    repeat (2) @(posedge clk);
    $display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout, the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
hw/rob_pkg.sv
hw/rob_alloc_if.sv
hw/rob_cmt_if.sv
hw/rob_entry_store.sv
hw/rob_retire_select.sv
hw/rob_cfg_regs.sv
hw/rob_top.sv
tb/rob_checker.sv
tb/rob_tb.sv

// ==== Bender.yml ====
package:
  name: rob_subsystem

sources:
  # RTL, in compile order
  - hw/rob_pkg.sv
  - hw/rob_alloc_if.sv
  - hw/rob_cmt_if.sv
  - hw/rob_entry_store.sv
  - hw/rob_retire_select.sv
  - hw/rob_cfg_regs.sv
  - hw/rob_top.sv
  # Testbench
  - target: simulation
    files:
      - tb/rob_checker.sv
      - tb/rob_tb.sv
